//--- design/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Datapath widths
`define FETCH_ADDR_W 32
`define FETCH_DATA_W 32

// Direct-mapped L1 with one word per line
`define ICACHE_IDX_W 6
`define ICACHE_TAG_W 24

// Instruction memory size in words (log2)
`define IMEM_WORD_W 10

// Cycles from accepted read to read data
`define IMEM_LATENCY 3

`endif

//--- design/fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  typedef logic [`FETCH_ADDR_W-1:0] addr_t;
  typedef logic [`FETCH_DATA_W-1:0] inst_t;

  // Line index taken from address bits above the byte offset
  typedef logic [`ICACHE_IDX_W-1:0] icache_idx_t;
  typedef logic [`ICACHE_TAG_W-1:0] icache_tag_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT,
    FETCH_HOLD
  } fetch_state_t;

endpackage

`default_nettype wire

//--- design/icache_l1.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module icache_l1
  import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst,

  input  wire         flush_i,

  input  wire addr_t  lookup_addr_i,
  output logic        hit_o,
  output inst_t       data_o,

  input  wire         fill_en_i,
  input  wire addr_t  fill_addr_i,
  input  wire inst_t  fill_data_i
);

  localparam int LINES = 1 << `ICACHE_IDX_W;

  inst_t            data_q [LINES];
  icache_tag_t      tag_q  [LINES];
  logic [LINES-1:0] valid_q;

  icache_idx_t      lookup_idx;
  icache_tag_t      lookup_tag;
  icache_idx_t      fill_idx;
  icache_tag_t      fill_tag;

  // Byte offset bits [1:0] are dropped
  assign lookup_idx = lookup_addr_i[2 +: `ICACHE_IDX_W];
  assign lookup_tag = lookup_addr_i[`FETCH_ADDR_W-1 -: `ICACHE_TAG_W];
  assign fill_idx   = fill_addr_i[2 +: `ICACHE_IDX_W];
  assign fill_tag   = fill_addr_i[`FETCH_ADDR_W-1 -: `ICACHE_TAG_W];

  assign hit_o  = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign data_o = data_q[lookup_idx];

  always_ff @(posedge clk)
  begin
    if (fill_en_i)
    begin
      data_q[fill_idx] <= fill_data_i;
      tag_q[fill_idx]  <= fill_tag;
    end
  end

  // A fill on the flush edge still lands
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else
    begin
      if (flush_i)
      begin
        valid_q <= '0;
      end
      if (fill_en_i)
      begin
        valid_q[fill_idx] <= 1'b1;
      end
    end
  end

  a_fill_addr_known: assert property (
    @(posedge clk) disable iff (rst)
    fill_en_i |-> !$isunknown(fill_addr_i)
  );

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst,

  input  wire         pc_valid_i,
  input  wire addr_t  pc_i,
  output logic        pc_ready_o,

  output logic        inst_valid_o,
  output inst_t       inst_o,
  output addr_t       inst_pc_o,
  input  wire         inst_ready_i,

  output logic        ar_valid_o,
  output addr_t       ar_addr_o,
  input  wire         ar_ready_i,
  input  wire         r_valid_i,
  input  wire inst_t  r_data_i,

  output addr_t       lookup_addr_o,
  input  wire         hit_i,
  input  wire inst_t  cache_data_i,
  output logic        fill_en_o,
  output addr_t       fill_addr_o,
  output inst_t       fill_data_o
);

  fetch_state_t state_q;
  logic         req_pending_q;
  addr_t        req_pc_q;
  logic         ar_valid_q;
  logic         inst_valid_q;
  inst_t        inst_q;
  addr_t        inst_pc_q;

  logic         pc_fire;
  logic         hit_load;
  logic         miss_load;
  logic         out_fire;

  // One request in flight, so no acceptance while looking up or holding
  assign pc_ready_o = (state_q == FETCH_IDLE) && !req_pending_q && !inst_valid_q;
  assign pc_fire    = pc_valid_i && pc_ready_o;
  assign hit_load   = (state_q == FETCH_IDLE) && req_pending_q && hit_i;
  assign miss_load  = (state_q == FETCH_WAIT) && r_valid_i;
  assign out_fire   = inst_valid_q && inst_ready_i;

  assign lookup_addr_o = req_pc_q;
  assign ar_valid_o    = ar_valid_q;
  assign ar_addr_o     = req_pc_q;

  // Fill on the same edge that loads the output register
  assign fill_en_o   = miss_load;
  assign fill_addr_o = req_pc_q;
  assign fill_data_o = r_data_i;

  assign inst_valid_o = inst_valid_q;
  assign inst_o       = inst_q;
  assign inst_pc_o    = inst_pc_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q       <= FETCH_IDLE;
      req_pending_q <= 1'b0;
      ar_valid_q    <= 1'b0;
      inst_valid_q  <= 1'b0;
    end
    else
    begin
      if (pc_fire)
      begin
        req_pending_q <= 1'b1;
      end
      case (state_q)
        FETCH_IDLE:
        begin
          // Tag compare happens the cycle after acceptance
          if (req_pending_q)
          begin
            req_pending_q <= 1'b0;
            if (hit_load)
            begin
              state_q      <= FETCH_HOLD;
              inst_valid_q <= 1'b1;
            end
            else
            begin
              state_q    <= FETCH_REQ;
              ar_valid_q <= 1'b1;
            end
          end
        end
        FETCH_REQ:
        begin
          if (ar_ready_i)
          begin
            state_q    <= FETCH_WAIT;
            ar_valid_q <= 1'b0;
          end
        end
        FETCH_WAIT:
        begin
          if (miss_load)
          begin
            state_q      <= FETCH_HOLD;
            inst_valid_q <= 1'b1;
          end
        end
        FETCH_HOLD:
        begin
          if (out_fire)
          begin
            state_q      <= FETCH_IDLE;
            inst_valid_q <= 1'b0;
          end
        end
        default:
        begin
          state_q <= FETCH_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (pc_fire)
    begin
      req_pc_q <= pc_i;
    end
    if (hit_load)
    begin
      inst_q    <= cache_data_i;
      inst_pc_q <= req_pc_q;
    end
    else if (miss_load)
    begin
      inst_q    <= r_data_i;
      inst_pc_q <= req_pc_q;
    end
  end

  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    inst_valid_o && !inst_ready_i |=> $stable(inst_o) && $stable(inst_pc_o)
  );

  a_ar_only_in_req: assert property (
    @(posedge clk) disable iff (rst)
    ar_valid_o |-> state_q == FETCH_REQ
  );

endmodule

`default_nettype wire

//--- design/inst_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module inst_mem
  import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst,

  input  wire         mem_we_i,
  input  wire addr_t  mem_waddr_i,
  input  wire inst_t  mem_wdata_i,

  input  wire         ar_valid_i,
  input  wire addr_t  ar_addr_i,
  output logic        ar_ready_o,
  output logic        r_valid_o,
  output inst_t       r_data_o
);

  localparam int WORDS = 1 << `IMEM_WORD_W;
  localparam int CNT_W = $clog2(`IMEM_LATENCY + 1);

  inst_t                  mem_q [WORDS];
  logic                   busy_q;
  logic [`IMEM_WORD_W-1:0] raddr_q;
  logic [CNT_W-1:0]       cnt_q;
  logic                   r_valid_q;
  inst_t                  r_data_q;

  assign ar_ready_o = !busy_q;
  assign r_valid_o  = r_valid_q;
  assign r_data_o   = r_data_q;

  // Host load port ignores upper address bits
  always_ff @(posedge clk)
  begin
    if (mem_we_i)
    begin
      mem_q[mem_waddr_i[2 +: `IMEM_WORD_W]] <= mem_wdata_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      r_valid_q <= 1'b0;
    end
    else
    begin
      r_valid_q <= 1'b0;
      if (ar_valid_i && !busy_q)
      begin
        busy_q  <= 1'b1;
        cnt_q   <= CNT_W'(`IMEM_LATENCY);
        raddr_q <= ar_addr_i[2 +: `IMEM_WORD_W];
      end
      else if (busy_q)
      begin
        cnt_q <= cnt_q - 1'b1;
        // Array is read at response time
        if (cnt_q == CNT_W'(1))
        begin
          busy_q    <= 1'b0;
          r_valid_q <= 1'b1;
          r_data_q  <= mem_q[raddr_q];
        end
      end
    end
  end

  a_r_valid_single: assert property (
    @(posedge clk) disable iff (rst)
    r_valid_o |=> !r_valid_o
  );

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst,

  input  wire         pc_valid_i,
  input  wire addr_t  pc_i,
  output logic        pc_ready_o,

  output logic        inst_valid_o,
  output inst_t       inst_o,
  output addr_t       inst_pc_o,
  input  wire         inst_ready_i,

  input  wire         flush_i,

  input  wire         mem_we_i,
  input  wire addr_t  mem_waddr_i,
  input  wire inst_t  mem_wdata_i
);

  // Bus read channel
  logic  ar_valid;
  addr_t ar_addr;
  logic  ar_ready;
  logic  r_valid;
  inst_t r_data;

  // Cache lookup and fill
  addr_t lookup_addr;
  logic  hit;
  inst_t cache_data;
  logic  fill_en;
  addr_t fill_addr;
  inst_t fill_data;

  fetch_unit u_fetch_unit (
    .clk           (clk),
    .rst           (rst),
    .pc_valid_i    (pc_valid_i),
    .pc_i          (pc_i),
    .pc_ready_o    (pc_ready_o),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o),
    .inst_ready_i  (inst_ready_i),
    .ar_valid_o    (ar_valid),
    .ar_addr_o     (ar_addr),
    .ar_ready_i    (ar_ready),
    .r_valid_i     (r_valid),
    .r_data_i      (r_data),
    .lookup_addr_o (lookup_addr),
    .hit_i         (hit),
    .cache_data_i  (cache_data),
    .fill_en_o     (fill_en),
    .fill_addr_o   (fill_addr),
    .fill_data_o   (fill_data)
  );

  icache_l1 u_icache_l1 (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .lookup_addr_i (lookup_addr),
    .hit_o         (hit),
    .data_o        (cache_data),
    .fill_en_i     (fill_en),
    .fill_addr_i   (fill_addr),
    .fill_data_i   (fill_data)
  );

  inst_mem u_inst_mem (
    .clk         (clk),
    .rst         (rst),
    .mem_we_i    (mem_we_i),
    .mem_waddr_i (mem_waddr_i),
    .mem_wdata_i (mem_wdata_i),
    .ar_valid_i  (ar_valid),
    .ar_addr_i   (ar_addr),
    .ar_ready_o  (ar_ready),
    .r_valid_o   (r_valid),
    .r_data_o    (r_data)
  );

endmodule

`default_nettype wire

//--- verification/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb
  import fetch_pkg::*;
();

  // About 300 fetches at a worst case near 12 cycles, plus stalls and margin
  localparam int CYCLE_LIMIT     = 20000;
  localparam int HANDSHAKE_BOUND = 50;
  localparam int MEM_WORDS       = 1 << `IMEM_WORD_W;

  logic  clk = 1'b0;
  logic  rst;
  logic  pc_valid;
  addr_t pc;
  logic  pc_ready;
  logic  inst_valid;
  inst_t inst;
  addr_t inst_pc;
  logic  inst_ready;
  logic  flush;
  logic  mem_we;
  addr_t mem_waddr;
  inst_t mem_wdata;

  inst_t       model_mem [MEM_WORDS];
  logic [31:0] lcg_state;
  int          cycle_count = 0;

  fetch_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .pc_valid_i   (pc_valid),
    .pc_i         (pc),
    .pc_ready_o   (pc_ready),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .inst_pc_o    (inst_pc),
    .inst_ready_i (inst_ready),
    .flush_i      (flush),
    .mem_we_i     (mem_we),
    .mem_waddr_i  (mem_waddr),
    .mem_wdata_i  (mem_wdata)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      stop_run();
    end
  end

  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper LCG bits have longer periods than the low ones
  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % 32'(n));
  endfunction

  function automatic addr_t rand_addr(input int base_word, input int words);
    return addr_t'(base_word + rand_below(words)) << 2;
  endfunction

  function automatic inst_t model_word(input addr_t a);
    return model_mem[a[2 +: `IMEM_WORD_W]];
  endfunction

  task automatic compare_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic load_word(input addr_t a, input inst_t d);
    mem_we    = 1'b1;
    mem_waddr = a;
    mem_wdata = d;
    model_mem[a[2 +: `IMEM_WORD_W]] = d;
    next_cycle();
    mem_we = 1'b0;
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
  endtask

  // One request, then the output held for stall cycles before taking it
  task automatic fetch_check(input string name, input addr_t a, input inst_t exp,
                             input int stall, output int latency);
    int waited;
    waited  = 0;
    latency = 0;
    while (!pc_ready)
    begin
      next_cycle();
      waited++;
      if (waited > HANDSHAKE_BOUND)
      begin
        $display("%s: fetch unit never became ready for a request", name);
        stop_run();
      end
    end
    pc_valid = 1'b1;
    pc       = a;
    next_cycle();
    pc_valid = 1'b0;
    pc       = '0;
    while (!inst_valid)
    begin
      next_cycle();
      latency++;
      if (latency > HANDSHAKE_BOUND)
      begin
        $display("%s: no instruction returned", name);
        stop_run();
      end
    end
    compare_inst(name, exp, inst);
    compare_addr({name, " pc"}, a, inst_pc);
    for (int i = 0; i < stall; i++)
    begin
      next_cycle();
      compare_bit({name, " valid held"}, 1'b1, inst_valid);
      compare_inst({name, " stalled"}, exp, inst);
      compare_addr({name, " stalled pc"}, a, inst_pc);
      compare_bit({name, " pc_ready stalled"}, 1'b0, pc_ready);
    end
    inst_ready = 1'b1;
    next_cycle();
    inst_ready = 1'b0;
    compare_bit({name, " valid after handshake"}, 1'b0, inst_valid);
  endtask

  task automatic test_reset_state();
    compare_bit("reset_state inst_valid", 1'b0, inst_valid);
    compare_bit("reset_state pc_ready", 1'b1, pc_ready);
  endtask

  task automatic test_miss_then_hit();
    addr_t a;
    inst_t w;
    int    lat;
    a = rand_addr(0, 64);
    w = lcg_next();
    load_word(a, w);
    fetch_check("miss_then_hit miss", a, w, 0, lat);
    compare_bit("miss_then_hit miss latency", 1'b1, lat > 1);
    fetch_check("miss_then_hit hit", a, w, 0, lat);
    compare_count("miss_then_hit hit latency", 1, lat);
  endtask

  // Same index bits with the tag differing in bit 10
  task automatic test_index_conflict();
    addr_t a;
    addr_t b;
    int    lat;
    a = rand_addr(64, 64);
    b = a + addr_t'(32'h400);
    load_word(a, lcg_next());
    load_word(b, lcg_next());
    for (int i = 0; i < 4; i++)
    begin
      fetch_check("index_conflict a", a, model_word(a), 0, lat);
      compare_bit("index_conflict a missed", 1'b1, lat > 1);
      fetch_check("index_conflict b", b, model_word(b), 0, lat);
      compare_bit("index_conflict b missed", 1'b1, lat > 1);
    end
  endtask

  task automatic test_back_pressure();
    addr_t a;
    int    lat;
    for (int i = 0; i < 8; i++)
    begin
      load_word(addr_t'(512 + i) << 2, lcg_next());
    end
    // Second round hits the lines filled by the first
    for (int r = 0; r < 2; r++)
    begin
      for (int i = 0; i < 8; i++)
      begin
        a = addr_t'(512 + i) << 2;
        fetch_check("back_pressure", a, model_word(a), rand_below(8) + 1, lat);
        if (r == 0)
        begin
          compare_bit("back_pressure first round missed", 1'b1, lat > 1);
        end
        else
        begin
          compare_count("back_pressure second round hit latency", 1, lat);
        end
      end
    end
  endtask

  task automatic test_stale_and_flush();
    addr_t a;
    inst_t old_w;
    inst_t new_w;
    int    lat;
    a     = rand_addr(768, 64);
    old_w = lcg_next();
    new_w = old_w ^ (lcg_next() | 32'h1);
    load_word(a, old_w);
    fetch_check("stale_and_flush first", a, old_w, 0, lat);
    load_word(a, new_w);
    fetch_check("stale_and_flush cached", a, old_w, 0, lat);
    compare_count("stale_and_flush cached latency", 1, lat);
    pulse_flush();
    fetch_check("stale_and_flush after flush", a, new_w, 0, lat);
    compare_bit("stale_and_flush refilled", 1'b1, lat > 1);
  endtask

  task automatic test_random_program();
    addr_t a;
    int    lat;
    for (int i = 0; i < 256; i++)
    begin
      load_word(addr_t'(i) << 2, lcg_next());
    end
    // Earlier tests left lines of this region in the cache
    pulse_flush();
    for (int i = 0; i < 200; i++)
    begin
      a = rand_addr(0, 256);
      fetch_check("random_program", a, model_word(a), rand_below(4), lat);
    end
  endtask

  initial
  begin
    lcg_state  = 32'h123e_2e59;
    rst        = 1'b1;
    pc_valid   = 1'b0;
    pc         = '0;
    inst_ready = 1'b0;
    flush      = 1'b0;
    mem_we     = 1'b0;
    mem_waddr  = '0;
    mem_wdata  = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    test_reset_state();
    test_miss_then_hit();
    test_index_conflict();
    test_back_pressure();
    test_stale_and_flush();
    test_random_program();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_top.f
+incdir+design
design/fetch_pkg.sv
design/icache_l1.sv
design/fetch_unit.sv
design/inst_mem.sv
design/fetch_top.sv
verification/fetch_tb.sv
